/* bench/idiv_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module idiv_tb
    import idiv_pkg::*;
();

    localparam int TABLE_N    = 23;
    localparam int RAND_N     = 40;
    localparam int TOTAL_N    = TABLE_N + RAND_N;
    localparam int WAIT_LIMIT = 1000;

    typedef struct packed {
        idiv_word_t dividend;
        idiv_word_t divisor;
        logic       is_signed;
        idiv_word_t quotient;
        idiv_word_t remainder;
    } div_case_t;

    logic       clk_i;
    logic       reset_i;
    logic       v_i;
    logic       signed_i;
    idiv_word_t dividend_i;
    idiv_word_t divisor_i;
    logic       yumi_i;
    logic       ready_o;
    logic       v_o;
    idiv_word_t quotient_o;
    idiv_word_t remainder_o;

    div_case_t   cases [TOTAL_N];
    div_case_t   pending [$];
    logic [31:0] lfsr;
    logic        timed_out;
    int          accepted;
    int          received;
    int          max_in_flight;
    int          quot_errors;
    int          rem_errors;
    int          flag_errors;
    int          other_errors;

    idiv_top DUT (
        .clk_i(clk_i), .reset_i(reset_i),
        .v_i(v_i), .ready_o(ready_o), .signed_i(signed_i),
        .dividend_i(dividend_i), .divisor_i(divisor_i),
        .v_o(v_o), .quotient_o(quotient_o), .remainder_o(remainder_o),
        .yumi_i(yumi_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // ======================================================================
    // stimulus sources and reference model
    // ======================================================================

    // fibonacci form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int nbits, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // truncating division on magnitudes, remainder follows the dividend
    task automatic model_divide(input idiv_word_t a, input idiv_word_t b, input logic s,
                                output idiv_word_t q, output idiv_word_t r);
        logic       neg_a;
        logic       neg_b;
        idiv_word_t mag_a;
        idiv_word_t mag_b;
        neg_a = s & a[$bits(idiv_word_t)-1];
        neg_b = s & b[$bits(idiv_word_t)-1];
        mag_a = neg_a ? -a : a;
        mag_b = neg_b ? -b : b;
        if (b == '0) begin
            q = '1;
            r = a;
        end else begin
            q = mag_a / mag_b;
            r = mag_a % mag_b;
            q = (neg_a ^ neg_b) ? -q : q;
            r = neg_a ? -r : r;
        end
    endtask

    task automatic set_case(input int idx, input idiv_word_t a, input idiv_word_t b,
                            input logic s, input idiv_word_t q, input idiv_word_t r);
        cases[idx] = '{a, b, s, q, r};
    endtask

    task automatic load_table();
        // unsigned
        set_case(0,  32'd100,       32'd7,         1'b0, 32'd14,        32'd2);
        set_case(1,  32'd5,         32'd9,         1'b0, 32'd0,         32'd5);
        set_case(2,  32'hffffffff,  32'd1,         1'b0, 32'hffffffff,  32'd0);
        set_case(3,  32'hffffffff,  32'd10,        1'b0, 32'h19999999,  32'd5);
        set_case(4,  32'h80000000,  32'd3,         1'b0, 32'h2aaaaaaa,  32'd2);
        set_case(5,  32'd0,         32'd5,         1'b0, 32'd0,         32'd0);
        set_case(6,  32'hffffffff,  32'hffffffff,  1'b0, 32'd1,         32'd0);
        set_case(7,  32'h12345678,  32'h00001000,  1'b0, 32'h00012345,  32'h678);
        // signed, all four sign combinations
        set_case(8,  32'd100,       32'd7,         1'b1, 32'd14,        32'd2);
        set_case(9,  32'hffffff9c,  32'd7,         1'b1, 32'hfffffff2,  32'hfffffffe);
        set_case(10, 32'd100,       32'hfffffff9,  1'b1, 32'hfffffff2,  32'd2);
        set_case(11, 32'hffffff9c,  32'hfffffff9,  1'b1, 32'd14,        32'hfffffffe);
        set_case(12, 32'hfffffff9,  32'd100,       1'b1, 32'd0,         32'hfffffff9);
        set_case(13, 32'd7,         32'd2,         1'b1, 32'd3,         32'd1);
        // zero divisor and the overflow corner
        set_case(14, 32'd1234,      32'd0,         1'b0, 32'hffffffff,  32'd1234);
        set_case(15, 32'hfffffffb,  32'd0,         1'b1, 32'hffffffff,  32'hfffffffb);
        set_case(16, 32'd5,         32'd0,         1'b1, 32'hffffffff,  32'd5);
        set_case(17, 32'h80000000,  32'hffffffff,  1'b1, 32'h80000000,  32'd0);
        set_case(18, 32'h80000000,  32'hffffffff,  1'b0, 32'd0,         32'h80000000);
        set_case(19, 32'h80000000,  32'd1,         1'b1, 32'h80000000,  32'd0);
        set_case(20, 32'h80000000,  32'd2,         1'b1, 32'hc0000000,  32'd0);
        set_case(21, 32'h7fffffff,  32'h80000000,  1'b1, 32'd0,         32'h7fffffff);
        set_case(22, 32'd0,         32'd0,         1'b0, 32'hffffffff,  32'd0);
    endtask

    task automatic make_random_cases();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sh;
        logic [31:0] sgn;
        idiv_word_t  q;
        idiv_word_t  r;
        for (int i = TABLE_N; i < TOTAL_N; i++) begin
            draw_bits(32, a);
            draw_bits(32, b);
            draw_bits(5, sh);
            draw_bits(1, sgn);
            // spread divisor sizes so both short and long quotients show up
            b = b >> sh[4:0];
            model_divide(a, b, sgn[0], q, r);
            set_case(i, a, b, sgn[0], q, r);
        end
    endtask

    // ======================================================================
    // compare tasks
    // ======================================================================

    task automatic check_quotient(input int idx, input idiv_word_t got, input idiv_word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: case %0d quotient %h, expected %h", $time, idx, got, exp);
            quot_errors++;
        end
    endtask

    task automatic check_remainder(input int idx, input idiv_word_t got, input idiv_word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: case %0d remainder %h, expected %h", $time, idx, got, exp);
            rem_errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
            flag_errors++;
        end
    endtask

    // ======================================================================
    // producer and consumer
    // ======================================================================

    task automatic send_all();
        int   wait_cnt;
        logic ready_seen;
        for (int i = 0; i < TOTAL_N && !timed_out; i++) begin
            v_i        <= 1'b1;
            signed_i   <= cases[i].is_signed;
            dividend_i <= cases[i].dividend;
            divisor_i  <= cases[i].divisor;
            ready_seen = 1'b0;
            wait_cnt   = 0;
            while (!ready_seen && !timed_out) begin
                @(negedge clk_i);
                if (!ready_o && accepted == received) begin
                    $display("ready_o dropped at %0t with no request in flight", $time);
                    other_errors++;
                end
                if (ready_o && (accepted - received) == 3) begin
                    $display("ready_o high at %0t with three requests in flight", $time);
                    other_errors++;
                end
                if (ready_o) begin
                    ready_seen = 1'b1;
                end else begin
                    wait_cnt++;
                    if (wait_cnt > WAIT_LIMIT) begin
                        $display("timed out waiting for ready_o on request %0d", i);
                        other_errors++;
                        timed_out = 1'b1;
                    end
                end
            end
            if (ready_seen) begin
                // transfer happens on this edge
                @(posedge clk_i);
                pending.push_back(cases[i]);
                accepted++;
                if (accepted - received > max_in_flight) begin
                    max_in_flight = accepted - received;
                end
            end
        end
        v_i <= 1'b0;
    endtask

    task automatic receive_all();
        int          wait_cnt;
        int          stretch;
        logic        got_v;
        logic        have_exp;
        logic [31:0] bits;
        div_case_t   exp;
        for (int n = 0; n < TOTAL_N && !timed_out; n++) begin
            got_v    = 1'b0;
            wait_cnt = 0;
            while (!got_v && !timed_out) begin
                @(negedge clk_i);
                if (v_o) begin
                    got_v = 1'b1;
                end else begin
                    wait_cnt++;
                    if (wait_cnt > WAIT_LIMIT) begin
                        $display("timed out waiting for result %0d on v_o", n);
                        other_errors++;
                        timed_out = 1'b1;
                    end
                end
            end
            if (got_v) begin
                have_exp = (pending.size() != 0);
                if (have_exp) begin
                    exp = pending.pop_front();
                    check_quotient(n, quotient_o, exp.quotient);
                    check_remainder(n, remainder_o, exp.remainder);
                end else begin
                    $display("result at %0t arrived with no request outstanding", $time);
                    other_errors++;
                end
                // first result held long so that requests pile up behind it
                draw_bits(3, bits);
                stretch = 0;
                if (n == 0) begin
                    stretch = 100;
                end else if (bits[2:0] >= 3'd5) begin
                    draw_bits(7, bits);
                    stretch = int'(bits[6:0]);
                end
                if (stretch > 0) begin
                    repeat (stretch) @(negedge clk_i);
                    check_flag("v_o under back-pressure", v_o, 1'b1);
                    if (have_exp) begin
                        check_quotient(n, quotient_o, exp.quotient);
                        check_remainder(n, remainder_o, exp.remainder);
                    end
                end
                @(posedge clk_i);
                yumi_i <= 1'b1;
                @(posedge clk_i);
                yumi_i <= 1'b0;
                received++;
            end
        end
    endtask

    initial begin
        reset_i       = 1'b1;
        v_i           = 1'b0;
        signed_i      = 1'b0;
        dividend_i    = '0;
        divisor_i     = '0;
        yumi_i        = 1'b0;
        lfsr          = 32'h42f0;
        timed_out     = 1'b0;
        accepted      = 0;
        received      = 0;
        max_in_flight = 0;
        quot_errors   = 0;
        rem_errors    = 0;
        flag_errors   = 0;
        other_errors  = 0;
        load_table();
        make_random_cases();

        repeat (8) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        check_flag("ready_o after reset", ready_o, 1'b1);
        check_flag("v_o after reset", v_o, 1'b0);
        @(posedge clk_i);

        fork
            send_all();
            receive_all();
        join

        if (pending.size() != 0 || accepted != received) begin
            $display("%0d requests accepted but %0d results taken", accepted, received);
            other_errors++;
        end
        if (max_in_flight < 3) begin
            $display("back-pressure never stacked three requests, peak was %0d", max_in_flight);
            other_errors++;
        end
        $display("errors: quotient %0d, remainder %0d, flag %0d, other %0d",
                 quot_errors, rem_errors, flag_errors, other_errors);
        if (quot_errors + rem_errors + flag_errors + other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+verilog
verilog/idiv_pkg.sv
verilog/idiv_operand_stage.sv
verilog/idiv_controller.sv
verilog/idiv_datapath.sv
verilog/idiv_result_buffer.sv
verilog/idiv_top.sv
bench/idiv_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the divider regression with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ns \
    -f flist.f \
    --top-module idiv_tb \
    -o idiv_sim

./obj_dir/idiv_sim | tee sim.log

if grep -qx "Regression passed" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* verilog/idiv_controller.sv */
`timescale 1ns/1ns
`default_nettype none

`include "idiv_defs.svh"

module idiv_controller
    import idiv_pkg::*;
(
    input  wire        clk_i,
    input  wire        reset_i,

    // operand stage
    input  wire        op_valid_i,
    input  wire        op_signed_i,
    input  wire        zero_divisor_i,
    output logic       op_take_o,

    // datapath status
    input  wire        adder_neg_i,
    input  wire        opa_neg_i,
    input  wire        opc_neg_i,

    // datapath control
    output logic       signed_r_o,
    output logic       opa_ld_o,
    output logic       opa_inv_o,
    output logic       opa_clr_l_o,
    output idiv_selb_e opb_sel_o,
    output logic       opb_ld_o,
    output logic       opb_inv_o,
    output logic       opb_clr_l_o,
    output idiv_selc_e opc_sel_o,
    output logic       opc_ld_o,
    output logic       adder_cin_o,

    // result buffer
    input  wire        res_full_i,
    output logic       res_load_o
);

    idiv_state_e state, next_state;
    idiv_count_t calc_cnt;
    logic        calc_done;
    logic        neg_ld;
    logic        signed_r;
    logic        zero_div_r;
    logic        q_neg;
    logic        r_neg;
    logic        add_neg_last;

    // ======================================================================
    // state and per-division flags
    // ======================================================================

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state <= WAIT;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            signed_r     <= 1'b0;
            zero_div_r   <= 1'b0;
            q_neg        <= 1'b0;
            r_neg        <= 1'b0;
            add_neg_last <= 1'b0;
        end else begin
            // sign of the previous step picks add or subtract
            add_neg_last <= adder_neg_i;
            if (op_take_o) begin
                signed_r   <= op_signed_i;
                zero_div_r <= zero_divisor_i;
            end
            // quotient negative when operand signs differ, remainder follows dividend
            if (neg_ld) begin
                q_neg <= opa_neg_i ^ opc_neg_i;
                r_neg <= opc_neg_i;
            end
        end
    end

    // datapath needs the flag already in the load cycle
    assign signed_r_o = (state == WAIT) ? op_signed_i : signed_r;

    // counts the IDIV_WIDTH+1 calculation steps
    assign calc_done = (calc_cnt == idiv_count_t'(`IDIV_WIDTH));

    always_ff @(posedge clk_i) begin
        if (reset_i || (state != CALC) || calc_done) begin
            calc_cnt <= '0;
        end else begin
            calc_cnt <= calc_cnt + 1'b1;
        end
    end

    // ======================================================================
    // sequencing
    // ======================================================================

    always_comb begin
        next_state  = state;
        op_take_o   = 1'b0;
        res_load_o  = 1'b0;
        neg_ld      = 1'b0;
        opa_ld_o    = 1'b0;
        opa_inv_o   = ~add_neg_last;
        opa_clr_l_o = 1'b1;
        opb_sel_o   = IDIV_SELB_SHIFT;
        opb_ld_o    = 1'b1;
        opb_inv_o   = 1'b0;
        opb_clr_l_o = 1'b1;
        opc_sel_o   = IDIV_SELC_SHIFT;
        opc_ld_o    = 1'b1;
        adder_cin_o = ~add_neg_last;

        case (state)
            WAIT: begin
                opc_sel_o = IDIV_SELC_INPUT;
                opb_ld_o  = 1'b0;
                opc_ld_o  = op_valid_i;
                if (op_valid_i) begin
                    op_take_o  = 1'b1;
                    opa_ld_o   = 1'b1;
                    next_state = NEG0;
                end
            end
            NEG0: begin
                // A becomes -A if negative, B picks up the dividend
                opa_inv_o   = 1'b1;
                opa_ld_o    = opa_neg_i;
                opb_clr_l_o = 1'b0;
                opb_sel_o   = IDIV_SELB_OPC;
                opc_ld_o    = 1'b0;
                adder_cin_o = 1'b1;
                neg_ld      = 1'b1;
                next_state  = opc_neg_i ? NEG1 : SHIFT;
            end
            NEG1: begin
                // C <= -B, magnitude of the dividend
                opa_clr_l_o = 1'b0;
                opb_inv_o   = 1'b1;
                opb_ld_o    = 1'b0;
                opc_sel_o   = IDIV_SELC_ADDER;
                adder_cin_o = 1'b1;
                next_state  = SHIFT;
            end
            SHIFT: begin
                opa_clr_l_o = 1'b0;
                opb_clr_l_o = 1'b0;
                adder_cin_o = 1'b0;
                next_state  = CALC;
            end
            CALC: begin
                if (calc_done) begin
                    // last step keeps the partial remainder unshifted
                    opb_sel_o  = IDIV_SELB_ADDER;
                    next_state = adder_neg_i ? REPAIR : REMAIN;
                end
            end
            REPAIR: begin
                opa_inv_o   = 1'b0;
                adder_cin_o = 1'b0;
                opb_sel_o   = IDIV_SELB_ADDER;
                opc_ld_o    = 1'b0;
                next_state  = REMAIN;
            end
            REMAIN: begin
                // remainder to A with its sign, quotient copied into B
                opa_ld_o    = 1'b1;
                opa_clr_l_o = 1'b0;
                opb_sel_o   = IDIV_SELB_OPC;
                opb_inv_o   = r_neg;
                adder_cin_o = r_neg;
                opc_ld_o    = 1'b0;
                next_state  = (zero_div_r || !q_neg) ? DONE : QUOT;
            end
            QUOT: begin
                opa_clr_l_o = 1'b0;
                opb_inv_o   = 1'b1;
                opb_ld_o    = 1'b0;
                opc_sel_o   = IDIV_SELC_ADDER;
                adder_cin_o = 1'b1;
                next_state  = DONE;
            end
            DONE: begin
                opb_ld_o = 1'b0;
                opc_ld_o = 1'b0;
                if (!res_full_i) begin
                    res_load_o = 1'b1;
                    next_state = WAIT;
                end
            end
            default: begin
                next_state = WAIT;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/idiv_datapath.sv */
`timescale 1ns/1ns
`default_nettype none

`include "idiv_defs.svh"

module idiv_datapath
    import idiv_pkg::*;
(
    input  wire        clk_i,

    input  idiv_word_t dividend_i,
    input  idiv_word_t divisor_i,
    input  wire        signed_r_i,

    // control from the FSM
    input  wire        opa_ld_i,
    input  wire        opa_inv_i,
    input  wire        opa_clr_l_i,
    input  idiv_selb_e opb_sel_i,
    input  wire        opb_ld_i,
    input  wire        opb_inv_i,
    input  wire        opb_clr_l_i,
    input  idiv_selc_e opc_sel_i,
    input  wire        opc_ld_i,
    input  wire        adder_cin_i,

    // status back to the FSM
    output logic       adder_neg_o,
    output logic       opa_neg_o,
    output logic       opc_neg_o,

    output idiv_word_t quotient_o,
    output idiv_word_t remainder_o
);

    // one extra bit on top of every register for the sign
    logic [`IDIV_WIDTH:0] opa_r, opb_r, opc_r;
    logic [`IDIV_WIDTH:0] opa_mux, opb_mux, opc_mux;
    logic [`IDIV_WIDTH:0] opa_in, opb_in;
    logic [`IDIV_WIDTH:0] add_out;
    logic [`IDIV_WIDTH:0] dividend_ext, divisor_ext;

    assign dividend_ext = {signed_r_i & dividend_i[`IDIV_WIDTH-1], dividend_i};
    assign divisor_ext  = {signed_r_i & divisor_i[`IDIV_WIDTH-1], divisor_i};

    // ======================================================================
    // source muxes
    // ======================================================================

    // A takes the divisor in the same cycle C takes the dividend
    assign opa_mux = (opc_sel_i == IDIV_SELC_INPUT) ? divisor_ext : add_out;

    always_comb begin
        case (opb_sel_i)
            IDIV_SELB_SHIFT: opb_mux = {add_out[`IDIV_WIDTH-1:0], opc_r[`IDIV_WIDTH]};
            IDIV_SELB_ADDER: opb_mux = add_out;
            IDIV_SELB_OPC:   opb_mux = opc_r;
            default:         opb_mux = '0;
        endcase
    end

    // quotient bit is set when the step did not go negative
    always_comb begin
        case (opc_sel_i)
            IDIV_SELC_SHIFT: opc_mux = {opc_r[`IDIV_WIDTH-1:0], ~add_out[`IDIV_WIDTH]};
            IDIV_SELC_ADDER: opc_mux = add_out;
            IDIV_SELC_INPUT: opc_mux = dividend_ext;
            default:         opc_mux = opc_r;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (opa_ld_i) begin
            opa_r <= opa_mux;
        end
        if (opb_ld_i) begin
            opb_r <= opb_mux;
        end
        if (opc_ld_i) begin
            opc_r <= opc_mux;
        end
    end

    // ======================================================================
    // shared adder
    // ======================================================================

    // invert plus carry-in gives subtraction and negation
    assign opa_in = opa_clr_l_i ? (opa_r ^ {(`IDIV_WIDTH+1){opa_inv_i}}) : '0;
    assign opb_in = opb_clr_l_i ? (opb_r ^ {(`IDIV_WIDTH+1){opb_inv_i}}) : '0;

    assign add_out = opa_in + opb_in + {{`IDIV_WIDTH{1'b0}}, adder_cin_i};

    assign adder_neg_o = add_out[`IDIV_WIDTH];
    assign opa_neg_o   = opa_r[`IDIV_WIDTH] & signed_r_i;
    assign opc_neg_o   = opc_r[`IDIV_WIDTH] & signed_r_i;

    // quotient ends in C, remainder in A
    assign quotient_o  = opc_r[`IDIV_WIDTH-1:0];
    assign remainder_o = opa_r[`IDIV_WIDTH-1:0];

endmodule

`default_nettype wire

/* verilog/idiv_defs.svh */
`ifndef IDIV_DEFS_SVH
`define IDIV_DEFS_SVH

// ======================================================================
// divider widths
// ======================================================================

// operand and result width
`define IDIV_WIDTH 32

// iteration counter width, must be able to count up to IDIV_WIDTH
`define IDIV_COUNT_W 6

`endif

/* verilog/idiv_operand_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module idiv_operand_stage
    import idiv_pkg::*;
(
    input  wire        clk_i,
    input  wire        reset_i,

    // request side
    input  wire        v_i,
    output logic       ready_o,
    input  wire        signed_i,
    input  idiv_word_t dividend_i,
    input  idiv_word_t divisor_i,

    // toward controller and datapath
    input  wire        take_i,
    output logic       valid_o,
    output logic       signed_o,
    output logic       zero_divisor_o,
    output idiv_word_t dividend_o,
    output idiv_word_t divisor_o
);

    logic       full_r;
    logic       accept;
    logic       signed_r;
    logic       zero_divisor_r;
    idiv_word_t dividend_r;
    idiv_word_t divisor_r;

    // one entry, so ready only while empty
    assign ready_o = ~full_r;
    assign accept  = v_i & ready_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            full_r <= 1'b0;
        end else if (accept) begin
            full_r <= 1'b1;
        end else if (take_i) begin
            full_r <= 1'b0;
        end
    end

    // request payload, zero divisor decoded once here
    always_ff @(posedge clk_i) begin
        if (accept) begin
            signed_r       <= signed_i;
            zero_divisor_r <= (divisor_i == '0);
            dividend_r     <= dividend_i;
            divisor_r      <= divisor_i;
        end
    end

    assign valid_o        = full_r;
    assign signed_o       = signed_r;
    assign zero_divisor_o = zero_divisor_r;
    assign dividend_o     = dividend_r;
    assign divisor_o      = divisor_r;

endmodule

`default_nettype wire

/* verilog/idiv_pkg.sv */
`default_nettype none

`include "idiv_defs.svh"

package idiv_pkg;

    typedef logic [`IDIV_WIDTH-1:0]   idiv_word_t;
    typedef logic [`IDIV_COUNT_W-1:0] idiv_count_t;

    // register B sources
    typedef enum logic [1:0] {
        IDIV_SELB_SHIFT = 2'd0,
        IDIV_SELB_ADDER = 2'd1,
        IDIV_SELB_OPC   = 2'd2
    } idiv_selb_e;

    // register C sources
    typedef enum logic [1:0] {
        IDIV_SELC_SHIFT = 2'd0,
        IDIV_SELC_ADDER = 2'd1,
        IDIV_SELC_INPUT = 2'd2
    } idiv_selc_e;

    typedef enum logic [3:0] {
        WAIT, NEG0, NEG1, SHIFT, CALC, REPAIR, REMAIN, QUOT, DONE
    } idiv_state_e;

endpackage

`default_nettype wire

/* verilog/idiv_result_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module idiv_result_buffer
    import idiv_pkg::*;
(
    input  wire        clk_i,
    input  wire        reset_i,

    // from controller and datapath
    input  wire        load_i,
    input  idiv_word_t quotient_i,
    input  idiv_word_t remainder_i,
    output logic       full_o,

    // consumer side
    output logic       v_o,
    output idiv_word_t quotient_o,
    output idiv_word_t remainder_o,
    input  wire        yumi_i
);

    logic       valid_r;
    idiv_word_t quotient_r;
    idiv_word_t remainder_r;

    // load only comes while empty, yumi only while full
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_r <= 1'b0;
        end else if (load_i) begin
            valid_r <= 1'b1;
        end else if (yumi_i) begin
            valid_r <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            quotient_r  <= quotient_i;
            remainder_r <= remainder_i;
        end
    end

    // same flag seen as full by the FSM and valid by the consumer
    assign full_o      = valid_r;
    assign v_o         = valid_r;
    assign quotient_o  = quotient_r;
    assign remainder_o = remainder_r;

endmodule

`default_nettype wire

/* verilog/idiv_top.sv */
`timescale 1ns/1ns
`default_nettype none

module idiv_top
    import idiv_pkg::*;
(
    input  wire        clk_i,
    input  wire        reset_i,

    input  wire        v_i,
    output logic       ready_o,
    input  wire        signed_i,
    input  idiv_word_t dividend_i,
    input  idiv_word_t divisor_i,

    output logic       v_o,
    output idiv_word_t quotient_o,
    output idiv_word_t remainder_o,
    input  wire        yumi_i
);

    // operand stage outputs
    logic       op_valid;
    logic       op_signed;
    logic       op_zero_divisor;
    idiv_word_t op_dividend;
    idiv_word_t op_divisor;
    logic       op_take;

    // controller to datapath
    logic       signed_r;
    logic       opa_ld, opa_inv, opa_clr_l;
    idiv_selb_e opb_sel;
    logic       opb_ld, opb_inv, opb_clr_l;
    idiv_selc_e opc_sel;
    logic       opc_ld;
    logic       adder_cin;
    logic       adder_neg, opa_neg, opc_neg;

    // datapath and controller to result buffer
    idiv_word_t quotient, remainder;
    logic       res_load, res_full;

    idiv_operand_stage u_operand_stage (
        .clk_i(clk_i), .reset_i(reset_i),
        .v_i(v_i), .ready_o(ready_o), .signed_i(signed_i),
        .dividend_i(dividend_i), .divisor_i(divisor_i),
        .take_i(op_take), .valid_o(op_valid), .signed_o(op_signed),
        .zero_divisor_o(op_zero_divisor),
        .dividend_o(op_dividend), .divisor_o(op_divisor)
    );

    idiv_controller u_controller (
        .clk_i(clk_i), .reset_i(reset_i),
        .op_valid_i(op_valid), .op_signed_i(op_signed),
        .zero_divisor_i(op_zero_divisor), .op_take_o(op_take),
        .adder_neg_i(adder_neg), .opa_neg_i(opa_neg), .opc_neg_i(opc_neg),
        .signed_r_o(signed_r),
        .opa_ld_o(opa_ld), .opa_inv_o(opa_inv), .opa_clr_l_o(opa_clr_l),
        .opb_sel_o(opb_sel), .opb_ld_o(opb_ld), .opb_inv_o(opb_inv),
        .opb_clr_l_o(opb_clr_l), .opc_sel_o(opc_sel), .opc_ld_o(opc_ld),
        .adder_cin_o(adder_cin),
        .res_full_i(res_full), .res_load_o(res_load)
    );

    idiv_datapath u_datapath (
        .clk_i(clk_i),
        .dividend_i(op_dividend), .divisor_i(op_divisor), .signed_r_i(signed_r),
        .opa_ld_i(opa_ld), .opa_inv_i(opa_inv), .opa_clr_l_i(opa_clr_l),
        .opb_sel_i(opb_sel), .opb_ld_i(opb_ld), .opb_inv_i(opb_inv),
        .opb_clr_l_i(opb_clr_l), .opc_sel_i(opc_sel), .opc_ld_i(opc_ld),
        .adder_cin_i(adder_cin),
        .adder_neg_o(adder_neg), .opa_neg_o(opa_neg), .opc_neg_o(opc_neg),
        .quotient_o(quotient), .remainder_o(remainder)
    );

    idiv_result_buffer u_result_buffer (
        .clk_i(clk_i), .reset_i(reset_i),
        .load_i(res_load), .quotient_i(quotient), .remainder_i(remainder),
        .full_o(res_full),
        .v_o(v_o), .quotient_o(quotient_o), .remainder_o(remainder_o),
        .yumi_i(yumi_i)
    );

endmodule

`default_nettype wire
